// ==== Makefile ====
# verilator build and run for the peripheral hub testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) common/periph_settings.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, the settings header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides the result, a missing pass line fails the target
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/periph_pkg.sv ====
// peripheral hub shared types
// command link format between host, queue and dispatcher,
// plus the dispatcher state encoding
package periph_pkg;

  // what a host command asks the hub to do
  typedef enum logic [1:0] {
    // leds take the data byte
    OP_LED_SET    = 2'd0,
    // leds xor'ed with the data byte
    OP_LED_TOGGLE = 2'd1,
    // data byte goes out on the uart
    OP_UART_SEND  = 2'd2,
    // uart sends {4'b0, dip switches}
    OP_DIP_REPORT = 2'd3
  } opcode_e;

  // one host command, 10 bits on the wire
  // op sits in the upper bits so a dump reads op first
  typedef struct packed {
    opcode_e    op;
    logic [7:0] data;
  } cmd_t;

  // dispatcher fsm
  typedef enum logic [1:0] {
    // waiting for a queued command
    IDLE      = 2'd0,
    // command latched, led strobe or uart request
    EXEC      = 2'd1,
    // uart still shifting the previous byte
    WAIT_UART = 2'd2
  } disp_state_e;

endpackage

// ==== common/periph_settings.svh ====
// peripheral hub build settings
// queue depth and uart bit timing, shared by rtl and testbench
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// queue entries, also the credits the host owns after reset
`define PERIPH_QUEUE_DEPTH 4

// clock cycles per uart bit with no speed-up
`define PERIPH_UART_BASE_CYCLES 64

// simulation speed-up as a shift
// 0 = real rate, 1 = 2x, 2 = 4x, 3 = 8x
`define PERIPH_UART_SPEEDUP 3

// effective bit period in clock cycles
// 64 >> 3 gives 8 cycles per bit
`define PERIPH_UART_BIT_CYCLES (`PERIPH_UART_BASE_CYCLES >> `PERIPH_UART_SPEEDUP)

`endif

// ==== hdl/cmd_dispatch.sv ====
// command dispatcher
// pops queued commands in order and turns them into led write
// strobes or uart byte requests, stalling while the uart is busy
module cmd_dispatch (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  periph_pkg::cmd_t i_cmd,
  output logic             o_pop,
  output logic             o_led_we,
  output logic             o_led_toggle,
  output logic [7:0]       o_led_data,
  input  logic [3:0]       i_dip,
  output logic             o_tx_start,
  output logic [7:0]       o_tx_byte,
  input  logic             i_tx_busy
);

  periph_pkg::disp_state_e state;
  periph_pkg::disp_state_e state_nxt;
  // command being executed, captured on pop
  periph_pkg::cmd_t        cur_cmd;
  logic                    is_led;
  logic                    want_tx;

  assign is_led = (cur_cmd.op == periph_pkg::OP_LED_SET) ||
                  (cur_cmd.op == periph_pkg::OP_LED_TOGGLE);

  // take the head whenever idle, queue output is already registered
  assign o_pop = (state == periph_pkg::IDLE) && i_valid;

  // led strobe lasts the single EXEC cycle
  assign o_led_we     = (state == periph_pkg::EXEC) && is_led;
  assign o_led_toggle = (cur_cmd.op == periph_pkg::OP_LED_TOGGLE);
  assign o_led_data   = cur_cmd.data;

  // uart request from EXEC directly, or later from WAIT_UART
  assign want_tx    = ((state == periph_pkg::EXEC) && !is_led) ||
                      (state == periph_pkg::WAIT_UART);
  assign o_tx_start = want_tx && !i_tx_busy;
  // switch value is sampled live, so it is the one seen at start
  assign o_tx_byte  = (cur_cmd.op == periph_pkg::OP_DIP_REPORT) ?
                      {4'b0000, i_dip} : cur_cmd.data;

  always_comb begin
    state_nxt = state;
    case (state)
      periph_pkg::IDLE: begin
        if (i_valid) begin
          state_nxt = periph_pkg::EXEC;
        end
      end
      periph_pkg::EXEC: begin
        // led done now; uart either starts now or has to wait
        if (is_led || !i_tx_busy) begin
          state_nxt = periph_pkg::IDLE;
        end else begin
          state_nxt = periph_pkg::WAIT_UART;
        end
      end
      periph_pkg::WAIT_UART: begin
        if (!i_tx_busy) begin
          state_nxt = periph_pkg::IDLE;
        end
      end
      default: state_nxt = periph_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= periph_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      cur_cmd <= i_cmd;
    end
  end

endmodule

// ==== hdl/cmd_queue.sv ====
// command queue
// circular buffer between the host port and the dispatcher;
// every pop hands one credit back to the host a cycle later
`include "periph_settings.svh"

module cmd_queue (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_push,
  input  periph_pkg::cmd_t   i_cmd,
  output logic               o_valid,
  output periph_pkg::cmd_t   o_cmd,
  input  logic               i_pop,
  output logic               o_credit
);

  localparam int DEPTH = `PERIPH_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  periph_pkg::cmd_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  assign full    = (count == CNT_W'(DEPTH));
  // push into a full queue is dropped, the host broke the credit rule
  assign push_ok = i_push && !full;
  assign pop_ok  = i_pop && o_valid;

  // head is visible the cycle after its push
  assign o_valid = (count != '0);
  assign o_cmd   = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_cmd;
    end
  end

  // pointers, occupancy and credit return
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit per released entry
      o_credit <= pop_ok;
    end
  end

endmodule

// ==== hdl/gpio_ctrl.sv ====
// gpio block
// led output register with set and toggle writes,
// two-flop synchronizer for the asynchronous dip switches
module gpio_ctrl (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_we,
  input  logic       i_toggle,
  input  logic [7:0] i_data,
  output logic [7:0] o_led,
  input  logic [3:0] i_dip,
  output logic [3:0] o_dip_sync
);

  // first synchronizer stage, may go metastable
  logic [3:0] dip_meta;

  // led register
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_led <= '0;
    end else if (i_we) begin
      // toggle flips the bits set in data, set overwrites
      o_led <= i_toggle ? (o_led ^ i_data) : i_data;
    end
  end

  // switch synchronizer
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      dip_meta   <= '0;
      o_dip_sync <= '0;
    end else begin
      dip_meta   <= i_dip;
      o_dip_sync <= dip_meta;
    end
  end

endmodule

// ==== hdl/periph_top.sv ====
// peripheral hub top level
// host command port with credit return feeding the queue,
// dispatcher, led/dip gpio and the uart transmitter
module periph_top (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_cmd_valid,
  input  periph_pkg::cmd_t i_cmd,
  output logic             o_credit,
  input  logic [3:0]       i_dip,
  output logic [7:0]       o_led,
  output logic             o_uart_txd
);

  // queue head towards the dispatcher
  logic             q_valid;
  periph_pkg::cmd_t q_cmd;
  logic             q_pop;
  // led write strobe
  logic             led_we;
  logic             led_toggle;
  logic [7:0]       led_data;
  logic [3:0]       dip_sync;
  // uart request and status
  logic             tx_start;
  logic [7:0]       tx_byte;
  logic             tx_busy;

  cmd_queue cmd_queue_i (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_push   (i_cmd_valid),
    .i_cmd    (i_cmd),
    .o_valid  (q_valid),
    .o_cmd    (q_cmd),
    .i_pop    (q_pop),
    .o_credit (o_credit)
  );

  cmd_dispatch cmd_dispatch_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (q_valid),
    .i_cmd        (q_cmd),
    .o_pop        (q_pop),
    .o_led_we     (led_we),
    .o_led_toggle (led_toggle),
    .o_led_data   (led_data),
    .i_dip        (dip_sync),
    .o_tx_start   (tx_start),
    .o_tx_byte    (tx_byte),
    .i_tx_busy    (tx_busy)
  );

  gpio_ctrl gpio_ctrl_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_we       (led_we),
    .i_toggle   (led_toggle),
    .i_data     (led_data),
    .o_led      (o_led),
    .i_dip      (i_dip),
    .o_dip_sync (dip_sync)
  );

  uart_tx uart_tx_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (tx_start),
    .i_byte  (tx_byte),
    .o_busy  (tx_busy),
    .o_txd   (o_uart_txd)
  );

endmodule

// ==== tb.f ====
+incdir+common
common/periph_pkg.sv
hdl/cmd_queue.sv
hdl/cmd_dispatch.sv
uart/uart_tx.sv
hdl/gpio_ctrl.sv
hdl/periph_top.sv
tb/periph_chk.sv
tb/tb_top.sv

// ==== tb/periph_chk.sv ====
// protocol checker for the peripheral hub
// bound into the top level, watches queue occupancy, credit return
// and the idle level of the uart line
`include "periph_settings.svh"

module periph_chk (
  input logic clk,
  input logic i_rst_n,
  input logic i_push,
  input logic i_pop,
  input logic i_credit,
  input logic i_tx_busy,
  input logic i_txd
);
  timeunit 1ns;
  timeprecision 100ps;

  // entries held by the queue, tracked from the host side
  int occ;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      occ <= 0;
    end else if (i_push && (occ < `PERIPH_QUEUE_DEPTH) && !i_pop) begin
      occ <= occ + 1;
    end else if (!(i_push && (occ < `PERIPH_QUEUE_DEPTH)) && i_pop) begin
      occ <= occ - 1;
    end
  end

  // a host that holds a credit never finds the queue full
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_push |-> (occ < `PERIPH_QUEUE_DEPTH))
    else $error("command pushed while the queue was full");

  // exactly one credit per pop, one cycle later
  a_credit_per_pop: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_credit == $past(i_pop))
    else $error("credit pulse does not match a pop in the previous cycle");

  // line rests high while the transmitter is free
  a_idle_high: assert property (@(posedge clk) disable iff (!i_rst_n)
    !i_tx_busy |-> i_txd)
    else $error("uart line low while the transmitter is idle");

endmodule

// ==== tb/tb_top.sv ====
// testbench for the peripheral hub
// credit-tracking host, uart line receiver, reference model of the
// led register and of the expected uart byte stream
`include "periph_settings.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BIT_CYC  = `PERIPH_UART_BIT_CYCLES;
  localparam int N_RANDOM = 200;
  // 200 cmds x 10 bits x 8 cycles is 16000 worst case
  // plus directed tests, dispatch gaps and margin
  localparam int TIMEOUT_CYCLES = 30000;

  logic             clk;
  logic             i_rst_n;
  logic             i_cmd_valid;
  periph_pkg::cmd_t i_cmd;
  logic             o_credit;
  logic [3:0]       i_dip;
  logic [7:0]       o_led;
  logic             o_uart_txd;

  // credits held by the host are depth + returned - sent
  int         sent_cnt = 0;
  int         credit_cnt = 0;
  int         cycle_cnt = 0;
  integer     seed;
  string      test_name = "init";
  // model state
  logic [7:0] model_led;
  logic [7:0] exp_bytes[$];
  logic [7:0] rx_bytes[$];

  periph_top periph_top_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_credit    (o_credit),
    .i_dip       (i_dip),
    .o_led       (o_led),
    .o_uart_txd  (o_uart_txd)
  );

  bind periph_top periph_chk periph_chk_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_push    (i_cmd_valid),
    .i_pop     (q_pop),
    .i_credit  (o_credit),
    .i_tx_busy (tx_busy),
    .i_txd     (o_uart_txd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      abort_run($sformatf("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                          test_name, what, exp_v, act_v));
    end
  endtask

  // reference model applied in issue order
  function automatic void apply_model(input periph_pkg::cmd_t c);
    case (c.op)
      periph_pkg::OP_LED_SET:    model_led = c.data;
      periph_pkg::OP_LED_TOGGLE: model_led = model_led ^ c.data;
      periph_pkg::OP_UART_SEND:  exp_bytes.push_back(c.data);
      // dip report sees the switches held steady while it is pending
      default:                   exp_bytes.push_back({4'b0000, i_dip});
    endcase
  endfunction

  // registered credit pulses are counted mid-cycle
  always @(negedge clk) begin
    if (i_rst_n && o_credit) begin
      credit_cnt++;
    end
  end

  // one push as soon as a credit is held
  // entered and left just after a rising edge
  task automatic send_cmd(input periph_pkg::cmd_t c);
    while (sent_cnt - credit_cnt >= `PERIPH_QUEUE_DEPTH) begin
      @(posedge clk);
      #1;
    end
    i_cmd_valid = 1'b1;
    i_cmd       = c;
    sent_cnt++;
    apply_model(c);
    @(posedge clk);
    #1;
    i_cmd_valid = 1'b0;
  endtask

  // all credits back and every expected byte seen
  task automatic drain();
    while ((credit_cnt < sent_cnt) || (exp_bytes.size() != 0)) begin
      @(posedge clk);
      #1;
    end
    // led register lands two cycles after the last pop
    repeat (2) @(posedge clk);
    #1;
  endtask

  // new switch value with time for the two-flop synchronizer
  task automatic set_dip(input logic [3:0] val);
    drain();
    i_dip = val;
    repeat (3) @(posedge clk);
    #1;
  endtask

  // line receiver with falling edge samples near mid-bit
  initial begin : uart_rx
    logic [7:0] rx_byte;
    @(posedge i_rst_n);
    forever begin
      @(negedge clk);
      if (o_uart_txd == 1'b0) begin
        repeat (BIT_CYC / 2) @(negedge clk);
        if (o_uart_txd !== 1'b0) begin
          abort_run("uart start bit ended before mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CYC) @(negedge clk);
          rx_byte[i] = o_uart_txd;
        end
        repeat (BIT_CYC) @(negedge clk);
        if (o_uart_txd !== 1'b1) begin
          abort_run("uart stop bit was low");
        end
        rx_bytes.push_back(rx_byte);
      end
    end
  end

  // compare received bytes against the model stream
  initial begin : compare
    logic [7:0] got;
    forever begin
      @(posedge clk);
      if (rx_bytes.size() != 0) begin
        got = rx_bytes.pop_front();
        if (exp_bytes.size() == 0) begin
          abort_run("uart byte received while none was expected");
        end
        check_value("uart byte", 32'(exp_bytes.pop_front()), 32'(got));
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    abort_run($sformatf("run timed out after %0d cycles, commands or credits stuck",
                        TIMEOUT_CYCLES));
  end

  initial begin : main
    periph_pkg::cmd_t c;
    logic [31:0]      r;
    seed        = 32'h93c6_9a4b;
    i_rst_n     = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_dip       = 4'h0;
    model_led   = 8'h00;
    repeat (4) @(posedge clk);
    #1;
    i_rst_n = 1'b1;

    // quiet outputs with nothing sent
    test_name = "reset";
    repeat (16) begin
      @(posedge clk);
      #1;
      check_value("o_led", 0, 32'(o_led));
      check_value("o_uart_txd", 1, 32'(o_uart_txd));
      check_value("o_credit", 0, 32'(o_credit));
    end

    test_name = "led";
    for (int n = 0; n < 12; n++) begin
      r      = $random(seed);
      c.op   = r[0] ? periph_pkg::OP_LED_TOGGLE : periph_pkg::OP_LED_SET;
      c.data = r[15:8];
      send_cmd(c);
    end
    drain();
    check_value("o_led", 32'(model_led), 32'(o_led));

    test_name = "uart send";
    for (int n = 0; n < 8; n++) begin
      r      = $random(seed);
      c.op   = periph_pkg::OP_UART_SEND;
      c.data = r[7:0];
      send_cmd(c);
    end
    drain();

    // all ones in the data byte show that a report does not send it
    test_name = "dip report";
    for (int n = 0; n < 4; n++) begin
      r = $random(seed);
      set_dip(r[3:0]);
      c.op   = periph_pkg::OP_DIP_REPORT;
      c.data = 8'hff;
      send_cmd(c);
    end
    drain();

    test_name = "random mix";
    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      c = periph_pkg::cmd_t'(r[9:0]);
      if ((c.op == periph_pkg::OP_DIP_REPORT) && (r[13:12] == 2'b00)) begin
        set_dip(r[19:16]);
      end
      send_cmd(c);
    end
    drain();
    // a stray frame on the line would reach the receiver by now
    repeat (10 * BIT_CYC) @(posedge clk);
    #1;
    check_value("credits returned", sent_cnt, credit_cnt);
    check_value("o_led", 32'(model_led), 32'(o_led));
    check_value("o_uart_txd idle", 1, 32'(o_uart_txd));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== uart/uart_tx.sv ====
// uart transmitter, 8N1
// start bit, eight data bits lsb first, one stop bit;
// bit period comes from the base rate and the sim speed-up shift
`include "periph_settings.svh"

module uart_tx (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_start,
  input  logic [7:0] i_byte,
  output logic       o_busy,
  output logic       o_txd
);

  localparam int BIT_CYCLES = `PERIPH_UART_BIT_CYCLES;
  localparam int CNT_W      = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
  // index of the stop bit, the last of ten periods
  localparam int LAST_BIT   = 9;

  // cycles spent in the current bit
  logic [CNT_W-1:0] cyc_cnt;
  // which of the ten bit periods is on the line
  logic [3:0]       bit_idx;
  // data bits still to send, stop bit on top
  logic [8:0]       shreg;
  logic             bit_end;
  logic             load;

  assign bit_end = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));
  // request is ignored while a frame is in flight
  assign load    = i_start && !o_busy;

  // control and line state
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_busy  <= 1'b0;
      o_txd   <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end else if (load) begin
      // start bit goes out right away
      o_busy  <= 1'b1;
      o_txd   <= 1'b0;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end else if (o_busy) begin
      if (bit_end) begin
        cyc_cnt <= '0;
        if (bit_idx == 4'(LAST_BIT)) begin
          // stop bit finished, line already high
          o_busy <= 1'b0;
          o_txd  <= 1'b1;
        end else begin
          o_txd   <= shreg[0];
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  // payload shifter
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, i_byte};
    end else if (o_busy && bit_end) begin
      // fill with ones, the line rests high
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule
